// File: include/pio_regs_settings.svh
`ifndef PIO_REGS_SETTINGS_SVH
`define PIO_REGS_SETTINGS_SVH

// bus and array sizes
`define PIO_DATA_W        32
`define PIO_ADDR_W        12
`define PIO_SM_COUNT      4
`define PIO_IMEM_DEPTH    32
`define PIO_INSTR_W       16

// global register map
`define PIO_CTRL_ADDR     12'h000
`define PIO_IRQ_ADDR      12'h030
`define PIO_IMEM_BASE     12'h048

// per machine windows, 0x18 bytes each
`define PIO_SM_BASE       12'h0C8
`define PIO_SM_STRIDE     12'h018
`define PIO_CLKDIV_OFS    12'h000
`define PIO_EXECCTRL_OFS  12'h004
`define PIO_SHIFTCTRL_OFS 12'h008
`define PIO_INSTR_OFS     12'h010
`define PIO_PINCTRL_OFS   12'h014

// writable bits
`define PIO_CTRL_MASK      32'h0000_000F
`define PIO_CLKDIV_MASK    32'hFFFF_FF00
`define PIO_EXECCTRL_MASK  32'h7FFF_FF9F
`define PIO_SHIFTCTRL_MASK 32'hFFFF_0000
`define PIO_INSTR_MASK     32'h0000_FFFF
`define PIO_IRQ_MASK       32'h0000_00FF

// reset values
`define PIO_CLKDIV_RST     32'h0001_0000
`define PIO_EXECCTRL_RST   32'h0001_F000
`define PIO_SHIFTCTRL_RST  32'h000C_0000
`define PIO_PINCTRL_RST    32'h1400_0000

`endif

// File: hw/pio_regs_pkg.sv
`include "pio_regs_settings.svh"

package pio_regs_pkg;

  typedef struct packed {
    logic [15:0] int_part;
    logic [7:0]  frac;
    logic [7:0]  reserved;
  } pio_clkdiv_t;

  typedef struct packed {
    logic       exec_stalled;
    logic       side_en;
    logic       side_pindir;
    logic [4:0] jmp_pin;
    logic [4:0] out_en_sel;
    logic       inline_out_en;
    logic       out_sticky;
    logic [4:0] wrap_top;
    logic [4:0] wrap_bottom;
    logic [1:0] reserved;
    logic       status_sel;
    logic [3:0] status_n;
  } pio_execctrl_t;

  typedef struct packed {
    logic        fjoin_rx;
    logic        fjoin_tx;
    logic [4:0]  pull_thresh;
    logic [4:0]  push_thresh;
    logic        out_shiftdir;
    logic        in_shiftdir;
    logic        autopull;
    logic        autopush;
    logic [15:0] reserved;
  } pio_shiftctrl_t;

  typedef struct packed {
    logic [2:0] sideset_count;
    logic [2:0] set_count;
    logic [5:0] out_count;
    logic [4:0] in_base;
    logic [4:0] sideset_base;
    logic [4:0] set_base;
    logic [4:0] out_base;
  } pio_pinctrl_t;

  // one storage word, viewed by the register it holds
  typedef union packed {
    pio_clkdiv_t             clkdiv;
    pio_execctrl_t           execctrl;
    pio_shiftctrl_t          shiftctrl;
    pio_pinctrl_t            pinctrl;
    logic [`PIO_DATA_W-1:0]  raw;
  } pio_sm_word_u;

  typedef enum logic [3:0] {
    TGT_NONE,
    TGT_CTRL,
    TGT_IRQ,
    TGT_IMEM,
    TGT_CLKDIV,
    TGT_EXECCTRL,
    TGT_SHIFTCTRL,
    TGT_INSTR,
    TGT_PINCTRL
  } pio_target_e;

endpackage

// File: hw/pio_req_if.sv
`timescale 1ns/10ps
`include "pio_regs_settings.svh"

interface pio_req_if;
  import pio_regs_pkg::*;

  logic                               wr;
  logic                               rd;
  pio_target_e                        target;
  logic [$clog2(`PIO_SM_COUNT)-1:0]   sm_index;
  logic [$clog2(`PIO_IMEM_DEPTH)-1:0] imem_index;
  logic [`PIO_DATA_W-1:0]             wdata;

  modport decoder (
    output wr, rd, target, sm_index, imem_index, wdata
  );

  modport sink (
    input wr, rd, target, sm_index, imem_index, wdata
  );

endinterface

// File: hw/pio_bus_decode.sv
`timescale 1ns/10ps
`include "pio_regs_settings.svh"

module pio_bus_decode (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   sel,
  input  logic                   rw,
  input  logic [`PIO_ADDR_W-1:0] addr,
  input  logic [`PIO_DATA_W-1:0] wdata,
  pio_req_if.decoder             req
);
  import pio_regs_pkg::*;

  localparam int SM_IDX_W   = $clog2(`PIO_SM_COUNT);
  localparam int IMEM_IDX_W = $clog2(`PIO_IMEM_DEPTH);
  localparam logic [`PIO_ADDR_W-1:0] IMEM_END =
    `PIO_IMEM_BASE + `PIO_ADDR_W'(4 * `PIO_IMEM_DEPTH);
  localparam logic [`PIO_ADDR_W-1:0] SM_END =
    `PIO_SM_BASE + `PIO_ADDR_W'(`PIO_SM_COUNT) * `PIO_SM_STRIDE;

  pio_target_e            tgt;
  logic [SM_IDX_W-1:0]    sm_idx;
  logic [`PIO_ADDR_W-1:0] imem_ofs;
  logic [`PIO_ADDR_W-1:0] sm_ofs;
  logic [`PIO_ADDR_W-1:0] fld_ofs;

  assign imem_ofs = addr - `PIO_IMEM_BASE;
  assign sm_ofs   = addr - `PIO_SM_BASE;

  always_comb begin
    tgt     = TGT_NONE;
    sm_idx  = '0;
    fld_ofs = sm_ofs;
    // last window whose base is not above the offset
    for (int i = 0; i < `PIO_SM_COUNT; i++) begin
      if (sm_ofs >= `PIO_ADDR_W'(i) * `PIO_SM_STRIDE) begin
        sm_idx  = SM_IDX_W'(i);
        fld_ofs = sm_ofs - `PIO_ADDR_W'(i) * `PIO_SM_STRIDE;
      end
    end

    if (addr == `PIO_CTRL_ADDR) begin
      tgt = TGT_CTRL;
    end else if (addr == `PIO_IRQ_ADDR) begin
      tgt = TGT_IRQ;
    end else if (addr >= `PIO_IMEM_BASE && addr < IMEM_END && addr[1:0] == 2'b00) begin
      tgt = TGT_IMEM;
    end else if (addr >= `PIO_SM_BASE && addr < SM_END) begin
      case (fld_ofs)
        `PIO_CLKDIV_OFS:    tgt = TGT_CLKDIV;
        `PIO_EXECCTRL_OFS:  tgt = TGT_EXECCTRL;
        `PIO_SHIFTCTRL_OFS: tgt = TGT_SHIFTCTRL;
        `PIO_INSTR_OFS:     tgt = TGT_INSTR;
        `PIO_PINCTRL_OFS:   tgt = TGT_PINCTRL;
        default:            tgt = TGT_NONE;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      req.wr     <= 1'b0;
      req.rd     <= 1'b0;
      req.target <= TGT_NONE;
    end else begin
      req.wr <= sel & rw;
      req.rd <= sel & ~rw;
      if (sel) begin
        req.target <= tgt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sel) begin
      req.sm_index   <= sm_idx;
      req.imem_index <= imem_ofs[IMEM_IDX_W+1:2];
      req.wdata      <= wdata;
    end
  end

endmodule

// File: hw/pio_sm_regs.sv
`timescale 1ns/10ps
`include "pio_regs_settings.svh"

module pio_sm_regs (
  input  logic                   clk,
  input  logic                   reset,
  pio_req_if.sink                req,
  output logic [`PIO_DATA_W-1:0] sm_rdata
);
  import pio_regs_pkg::*;

  localparam int FIELD_COUNT = 5;
  localparam logic [2:0] FLD_CLKDIV    = 3'd0;
  localparam logic [2:0] FLD_EXECCTRL  = 3'd1;
  localparam logic [2:0] FLD_SHIFTCTRL = 3'd2;
  localparam logic [2:0] FLD_INSTR     = 3'd3;
  localparam logic [2:0] FLD_PINCTRL   = 3'd4;

  pio_sm_word_u sm_word [`PIO_SM_COUNT][FIELD_COUNT];
  pio_sm_word_u wr_word;
  logic [2:0]   field;
  logic         hit;

  // masked write word, built through the view of the addressed register
  always_comb begin
    hit         = 1'b1;
    field       = FLD_CLKDIV;
    wr_word.raw = req.wdata;
    case (req.target)
      TGT_CLKDIV: begin
        field          = FLD_CLKDIV;
        wr_word.clkdiv = pio_clkdiv_t'(req.wdata & `PIO_CLKDIV_MASK);
      end
      TGT_EXECCTRL: begin
        field            = FLD_EXECCTRL;
        wr_word.execctrl = pio_execctrl_t'(req.wdata & `PIO_EXECCTRL_MASK);
      end
      TGT_SHIFTCTRL: begin
        field             = FLD_SHIFTCTRL;
        wr_word.shiftctrl = pio_shiftctrl_t'(req.wdata & `PIO_SHIFTCTRL_MASK);
      end
      TGT_INSTR: begin
        field       = FLD_INSTR;
        wr_word.raw = req.wdata & `PIO_INSTR_MASK;
      end
      TGT_PINCTRL: begin
        field           = FLD_PINCTRL;
        wr_word.pinctrl = pio_pinctrl_t'(req.wdata);
      end
      default: begin
        hit = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int m = 0; m < `PIO_SM_COUNT; m++) begin
        sm_word[m][FLD_CLKDIV].clkdiv       <= pio_clkdiv_t'(`PIO_CLKDIV_RST);
        sm_word[m][FLD_EXECCTRL].execctrl   <= pio_execctrl_t'(`PIO_EXECCTRL_RST);
        sm_word[m][FLD_SHIFTCTRL].shiftctrl <= pio_shiftctrl_t'(`PIO_SHIFTCTRL_RST);
        sm_word[m][FLD_INSTR].raw           <= '0;
        sm_word[m][FLD_PINCTRL].pinctrl     <= pio_pinctrl_t'(`PIO_PINCTRL_RST);
      end
    end else if (req.wr && hit) begin
      sm_word[req.sm_index][field] <= wr_word;
    end
  end

  // zero for targets outside the machine windows
  assign sm_rdata = hit ? sm_word[req.sm_index][field].raw : '0;

endmodule

// File: hw/pio_global_regs.sv
`timescale 1ns/10ps
`include "pio_regs_settings.svh"

module pio_global_regs (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               irq_set,
  input  logic [2:0]                         irq_index,
  input  logic                               irq_value,
  pio_req_if.sink                            req,
  output logic [`PIO_DATA_W-1:0]             global_rdata,
  output logic [`PIO_SM_COUNT-1:0]           sm_enable,
  output logic [$clog2(`PIO_IMEM_DEPTH)-1:0] instr_waddr,
  output logic [`PIO_INSTR_W-1:0]            instr_wdata,
  output logic                               instr_we
);
  import pio_regs_pkg::*;

  logic [`PIO_SM_COUNT-1:0] ctrl_q;
  logic [7:0]               irq_q;
  logic [`PIO_DATA_W-1:0]   ctrl_wr;
  logic [`PIO_DATA_W-1:0]   irq_wr;
  logic                     imem_wr;

  // restart bits fall outside the mask
  assign ctrl_wr = req.wdata & `PIO_CTRL_MASK;
  assign irq_wr  = req.wdata & `PIO_IRQ_MASK;
  assign imem_wr = req.wr && (req.target == TGT_IMEM);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ctrl_q   <= '0;
      irq_q    <= '0;
      instr_we <= 1'b0;
    end else begin
      instr_we <= imem_wr;
      if (req.wr && req.target == TGT_CTRL) begin
        ctrl_q <= ctrl_wr[`PIO_SM_COUNT-1:0];
      end
      // bus write beats the set port
      if (req.wr && req.target == TGT_IRQ) begin
        irq_q <= irq_wr[7:0];
      end else if (irq_set) begin
        irq_q[irq_index] <= irq_value;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (imem_wr) begin
      instr_waddr <= req.imem_index;
      instr_wdata <= req.wdata[`PIO_INSTR_W-1:0];
    end
  end

  always_comb begin
    case (req.target)
      TGT_CTRL: global_rdata = {{(`PIO_DATA_W - `PIO_SM_COUNT){1'b0}}, ctrl_q};
      TGT_IRQ:  global_rdata = {{(`PIO_DATA_W - 8){1'b0}}, irq_q};
      default:  global_rdata = '0;
    endcase
  end

  assign sm_enable = ctrl_q;

endmodule

// File: hw/pio_read_mux.sv
`timescale 1ns/10ps
`include "pio_regs_settings.svh"

module pio_read_mux (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`PIO_DATA_W-1:0] sm_rdata,
  input  logic [`PIO_DATA_W-1:0] global_rdata,
  pio_req_if.sink                req,
  output logic [`PIO_DATA_W-1:0] rdata
);
  import pio_regs_pkg::*;

  logic [`PIO_DATA_W-1:0] rd_word;

  always_comb begin
    case (req.target)
      TGT_CLKDIV, TGT_EXECCTRL, TGT_SHIFTCTRL, TGT_INSTR, TGT_PINCTRL:
        rd_word = sm_rdata;
      TGT_CTRL, TGT_IRQ:
        rd_word = global_rdata;
      default:
        rd_word = '0;
    endcase
  end

  // holds until the next read
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rdata <= '0;
    end else if (req.rd) begin
      rdata <= rd_word;
    end
  end

endmodule

// File: hw/pio_regs_top.sv
`timescale 1ns/10ps
`include "pio_regs_settings.svh"

module pio_regs_top (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               sel,
  input  logic                               rw,
  input  logic [`PIO_ADDR_W-1:0]             addr,
  input  logic [`PIO_DATA_W-1:0]             wdata,
  input  logic                               irq_set,
  input  logic [2:0]                         irq_index,
  input  logic                               irq_value,
  output logic [`PIO_DATA_W-1:0]             rdata,
  output logic [`PIO_SM_COUNT-1:0]           sm_enable,
  output logic [$clog2(`PIO_IMEM_DEPTH)-1:0] instr_waddr,
  output logic [`PIO_INSTR_W-1:0]            instr_wdata,
  output logic                               instr_we
);

  logic [`PIO_DATA_W-1:0] sm_rdata;
  logic [`PIO_DATA_W-1:0] global_rdata;

  pio_req_if req ();

  pio_bus_decode u_bus_decode (
    .clk   (clk),
    .reset (reset),
    .sel   (sel),
    .rw    (rw),
    .addr  (addr),
    .wdata (wdata),
    .req   (req.decoder)
  );

  pio_sm_regs u_sm_regs (
    .clk      (clk),
    .reset    (reset),
    .req      (req.sink),
    .sm_rdata (sm_rdata)
  );

  pio_global_regs u_global_regs (
    .clk          (clk),
    .reset        (reset),
    .irq_set      (irq_set),
    .irq_index    (irq_index),
    .irq_value    (irq_value),
    .req          (req.sink),
    .global_rdata (global_rdata),
    .sm_enable    (sm_enable),
    .instr_waddr  (instr_waddr),
    .instr_wdata  (instr_wdata),
    .instr_we     (instr_we)
  );

  pio_read_mux u_read_mux (
    .clk          (clk),
    .reset        (reset),
    .sm_rdata     (sm_rdata),
    .global_rdata (global_rdata),
    .req          (req.sink),
    .rdata        (rdata)
  );

endmodule

// File: tb/pio_regs_clkgen.sv
`timescale 1ns/10ps

module pio_regs_clkgen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // released between two rising edges
  initial begin
    reset = 1'b1;
    #(PERIOD * RESET_CYCLES);
    reset = 1'b0;
  end

endmodule

// File: tb/pio_regs_properties.sv
`timescale 1ns/10ps
`include "pio_regs_settings.svh"

module pio_regs_properties (
  input logic                     clk,
  input logic                     reset,
  input logic                     sel,
  input logic                     rw,
  input logic [`PIO_ADDR_W-1:0]   addr,
  input logic [`PIO_DATA_W-1:0]   wdata,
  input logic [`PIO_DATA_W-1:0]   rdata,
  input logic [`PIO_SM_COUNT-1:0] sm_enable,
  input logic                     instr_we
);

  logic imem_write;
  logic ctrl_write;

  // aligned word inside the instruction window
  assign imem_write = sel && rw && addr[1:0] == 2'b00 && addr >= `PIO_IMEM_BASE &&
    addr < `PIO_IMEM_BASE + `PIO_ADDR_W'(4 * `PIO_IMEM_DEPTH);
  assign ctrl_write = sel && rw && addr == `PIO_CTRL_ADDR;

  a_we_follows_write: assert property (@(posedge clk) disable iff (reset)
    imem_write |-> ##2 instr_we)
    else $error("instr_we missing two edges after an instruction write");

  a_we_only_after_write: assert property (@(posedge clk) disable iff (reset)
    instr_we |-> $past(imem_write, 2))
    else $error("instr_we high without an instruction write two edges before");

  a_rdata_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(rdata))
    else $error("rdata has unknown bits");

  // enables show the written word with restart bits cleared
  a_enable_from_ctrl: assert property (@(posedge clk) disable iff (reset)
    $past(ctrl_write, 2) |->
      `PIO_DATA_W'(sm_enable) == ($past(wdata, 2) & `PIO_CTRL_MASK))
    else $error("sm_enable differs from the masked control write");

endmodule

bind pio_regs_top pio_regs_properties u_properties (
  .clk       (clk),
  .reset     (reset),
  .sel       (sel),
  .rw        (rw),
  .addr      (addr),
  .wdata     (wdata),
  .rdata     (rdata),
  .sm_enable (sm_enable),
  .instr_we  (instr_we)
);

// File: tb/pio_regs_tb.sv
`timescale 1ns/10ps
`include "pio_regs_settings.svh"

module pio_regs_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  // accesses of reset, machine, imem, irq, back to back and hole tests
  localparam int N_ACCESSES   = 22 + 110 + 34 + 6 + 4 + 42;
  localparam int TIMEOUT_NS   = (N_ACCESSES * 4 + RESET_CYCLES + 50) * CLK_PERIOD;
  localparam logic [`PIO_ADDR_W-1:0] FIELD_OFS [5] = '{`PIO_CLKDIV_OFS, `PIO_EXECCTRL_OFS,
    `PIO_SHIFTCTRL_OFS, `PIO_INSTR_OFS, `PIO_PINCTRL_OFS};
  localparam logic [`PIO_DATA_W-1:0] FIELD_MASK [5] = '{`PIO_CLKDIV_MASK, `PIO_EXECCTRL_MASK,
    `PIO_SHIFTCTRL_MASK, `PIO_INSTR_MASK, 32'hFFFF_FFFF};
  localparam logic [`PIO_DATA_W-1:0] FIELD_RST [5] = '{`PIO_CLKDIV_RST, `PIO_EXECCTRL_RST,
    `PIO_SHIFTCTRL_RST, 32'h0, `PIO_PINCTRL_RST};
  // global holes, offset 0x0C of each machine is added on top
  localparam logic [`PIO_ADDR_W-1:0] HOLES [6] = '{12'h004, 12'h02C, 12'h044, 12'h04A,
    12'h128, 12'hFFC};

  logic clk, reset, sel, rw, irq_set, irq_value, instr_we;
  logic [2:0] irq_index;
  logic [4:0] instr_waddr;
  logic [`PIO_SM_COUNT-1:0] sm_enable;
  logic [`PIO_ADDR_W-1:0] addr;
  logic [`PIO_INSTR_W-1:0] instr_wdata;
  logic [`PIO_DATA_W-1:0] wdata, rdata;
  logic [`PIO_DATA_W-1:0] exp_sm [`PIO_SM_COUNT][5];
  logic [`PIO_SM_COUNT-1:0] exp_ctrl;
  logic [7:0] exp_irq;
  int errors;
  bit finished;

  pio_regs_clkgen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clkgen (.clk, .reset);

  pio_regs_top u_pio_regs_top (.*);

  function automatic logic [`PIO_ADDR_W-1:0] sm_addr(input int m, input int f);
    return `PIO_SM_BASE + `PIO_ADDR_W'(m) * `PIO_SM_STRIDE + FIELD_OFS[f];
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("ERR @%0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // called 2 ns after a rising edge, returns 2 ns after edge T
  task automatic bus_write(input logic [`PIO_ADDR_W-1:0] a, input logic [31:0] d);
    sel = 1'b1;
    rw = 1'b1;
    addr = a;
    wdata = d;
    @(posedge clk);
    #2;
    sel = 1'b0;
  endtask

  task automatic bus_read(input logic [`PIO_ADDR_W-1:0] a, output logic [31:0] d);
    sel = 1'b1;
    rw = 1'b0;
    addr = a;
    @(posedge clk);
    #2;
    sel = 1'b0;
    @(posedge clk);
    #2;
    d = rdata;
  endtask

  task automatic read_check(input logic [`PIO_ADDR_W-1:0] a, input logic [31:0] exp,
                            input string what);
    logic [31:0] got;
    bus_read(a, got);
    check(got, exp, what);
  endtask

  task automatic verify_all();
    for (int m = 0; m < `PIO_SM_COUNT; m++) begin
      for (int f = 0; f < 5; f++) begin
        read_check(sm_addr(m, f), exp_sm[m][f], $sformatf("sm%0d reg %0d", m, f));
      end
    end
    read_check(`PIO_CTRL_ADDR, 32'(exp_ctrl), "ctrl");
    read_check(`PIO_IRQ_ADDR, 32'(exp_irq), "irq flags");
  endtask

  task automatic reset_values();
    for (int m = 0; m < `PIO_SM_COUNT; m++) begin
      for (int f = 0; f < 5; f++) begin
        exp_sm[m][f] = FIELD_RST[f];
      end
    end
    exp_ctrl = '0;
    exp_irq = '0;
    verify_all();
  endtask

  task automatic sm_register_access();
    logic [31:0] v;
    for (int m = 0; m < `PIO_SM_COUNT; m++) begin
      for (int f = 0; f < 5; f++) begin
        v = $urandom;
        bus_write(sm_addr(m, f), v);
        exp_sm[m][f] = v & FIELD_MASK[f];
      end
      // other machines must still hold their old words
      verify_all();
    end
    v = $urandom;
    bus_write(`PIO_CTRL_ADDR, v);
    exp_ctrl = `PIO_SM_COUNT'(v & `PIO_CTRL_MASK);
    read_check(`PIO_CTRL_ADDR, 32'(exp_ctrl), "ctrl");
    check(32'(sm_enable), 32'(exp_ctrl), "sm_enable");
  endtask

  task automatic imem_port_pulses();
    logic [31:0] v;
    for (int i = 0; i < `PIO_IMEM_DEPTH; i++) begin
      v = $urandom;
      bus_write(`PIO_IMEM_BASE + `PIO_ADDR_W'(4 * i), v);
      check(32'(instr_we), 32'd0, "instr_we before pulse");
      @(posedge clk);
      #2;
      check(32'(instr_we), 32'd1, "instr_we pulse");
      check(32'(instr_waddr), 32'(i), "instr_waddr");
      check(32'(instr_wdata), 32'(v[15:0]), "instr_wdata");
      @(posedge clk);
      #2;
      check(32'(instr_we), 32'd0, "instr_we after pulse");
    end
    read_check(`PIO_IMEM_BASE + 12'h008, 32'd0, "imem read");
    check(32'(instr_we), 32'd0, "instr_we after imem read");
    bus_write(`PIO_CTRL_ADDR, 32'(exp_ctrl));
    @(posedge clk);
    #2;
    check(32'(instr_we), 32'd0, "instr_we after ctrl write");
  endtask

  task automatic irq_flag_merge();
    logic [31:0] v;
    logic [2:0] idx;
    v = $urandom;
    bus_write(`PIO_IRQ_ADDR, v);
    exp_irq = v[7:0];
    read_check(`PIO_IRQ_ADDR, 32'(exp_irq), "irq after bus write");
    idx = 3'($urandom);
    irq_index = idx;
    irq_value = ~exp_irq[idx];
    irq_set = 1'b1;
    @(posedge clk);
    #2;
    irq_set = 1'b0;
    exp_irq[idx] = ~exp_irq[idx];
    read_check(`PIO_IRQ_ADDR, 32'(exp_irq), "irq after set port");
    // set port held across the edge where the bus write lands
    v = $urandom;
    idx = 3'($urandom);
    irq_index = idx;
    irq_value = ~v[idx];
    irq_set = 1'b1;
    bus_write(`PIO_IRQ_ADDR, v);
    @(posedge clk);
    #2;
    irq_set = 1'b0;
    exp_irq = v[7:0];
    read_check(`PIO_IRQ_ADDR, 32'(exp_irq), "irq after collision");
  endtask

  task automatic back_to_back_and_holes();
    logic [31:0] v;
    v = $urandom;
    bus_write(sm_addr(2, 4), v);
    exp_sm[2][4] = v & FIELD_MASK[4];
    read_check(sm_addr(2, 4), exp_sm[2][4], "sm2 pinctrl back to back");
    v = $urandom;
    bus_write(sm_addr(1, 1), v);
    exp_sm[1][1] = v & FIELD_MASK[1];
    read_check(sm_addr(1, 1), exp_sm[1][1], "sm1 execctrl back to back");
    for (int h = 0; h < 6 + `PIO_SM_COUNT; h++) begin
      addr = (h < 6) ? HOLES[h] : sm_addr(h - 6, 0) + 12'h00C;
      bus_write(addr, $urandom);
      read_check(addr, 32'd0, $sformatf("hole %h", addr));
    end
    verify_all();
  endtask

  initial begin
    #(TIMEOUT_NS);
    finished = 1'b1;
    $display("timeout: tests did not finish within %0d ns", TIMEOUT_NS);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    errors = 0;
    void'($urandom(32'hcf57_7f2e));
    sel = 1'b0;
    rw = 1'b0;
    addr = '0;
    wdata = '0;
    irq_set = 1'b0;
    irq_index = '0;
    irq_value = 1'b0;
    @(negedge reset);
    @(posedge clk);
    #2;
    reset_values();
    sm_register_access();
    imem_port_pulses();
    irq_flag_merge();
    back_to_back_and_holes();
    finished = 1'b1;
    $display("run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // an assertion stop ends the run early
  final begin
    if (!finished) begin
      $display("** FAIL **");
    end
  end

endmodule

// File: pio_regs.f
+incdir+include
hw/pio_regs_pkg.sv
hw/pio_req_if.sv
hw/pio_bus_decode.sv
hw/pio_sm_regs.sv
hw/pio_global_regs.sv
hw/pio_read_mux.sv
hw/pio_regs_top.sv
tb/pio_regs_clkgen.sv
tb/pio_regs_properties.sv
tb/pio_regs_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f pio_regs.f --top-module pio_regs_tb \
    -o pio_regs_sim; then
  echo "verilator build failed"
  exit 1
fi

if ! sim_out="$(./obj_dir/pio_regs_sim)"; then
  echo "$sim_out"
  echo "simulation exited with an error status"
  exit 1
fi
echo "$sim_out"

if grep -qxF "** PASS **" <<< "$sim_out"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
